/* verilog.f */
src/cache_pkg.sv
src/bus_pkg.sv
src/set_ram.sv
src/dcache_ctrl.sv
src/dcache_top.sv
sim/mem_model.sv
sim/dcache_checker.sv
sim/tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - src/cache_pkg.sv
  - src/bus_pkg.sv
  - src/set_ram.sv
  - src/dcache_ctrl.sv
  - src/dcache_top.sv
  - target: test
    files:
      - sim/mem_model.sv
      - sim/dcache_checker.sv
      - sim/tb_dcache.sv

/* sim/tb_dcache.sv */
`timescale 1ns/100ps

// random loads and stores on a small conflicting address set
module tb_dcache;
    import bus_pkg::*;

    localparam int num_req   = 300;
    localparam int max_delay = 3;
    // request seen, addr stall, addr_ok, data stall, data_ok
    localparam int xfer_len  = 2 * max_delay + 3;
    // write-back and refill, plus the idle gap and the ack cycle
    localparam int worst_req = 2 * xfer_len + 2;
    localparam int cycle_limit = num_req * worst_req + 50;

    logic        clk;
    logic        rst;
    cpu_req_t    cpu_req;
    cpu_rsp_t    cpu_rsp;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    int          err_count;
    int          done_count;
    int          wb_count;
    int          rd_count;
    int          cycles;
    logic [31:0] lfsr = 32'h3534a656;

    dcache_top dut_i (
        .clk     (clk),
        .rst     (rst),
        .cpu_req (cpu_req),
        .cpu_rsp (cpu_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    mem_model mem_i (
        .clk      (clk),
        .rst      (rst),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp),
        .wb_count (wb_count),
        .rd_count (rd_count)
    );

    dcache_checker check_i (
        .clk        (clk),
        .rst        (rst),
        .cpu_req    (cpu_req),
        .cpu_rsp    (cpu_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .err_count  (err_count),
        .done_count (done_count)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // x^32 + x^22 + x^2 + x + 1
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // one request, held until data_ok
    task automatic issue_random();
        logic [1:0] tsel;
        logic [1:0] isel;
        logic [1:0] size;
        logic [1:0] off;
        tsel = 2'(rand_bits(2));
        isel = 2'(rand_bits(2));
        size = 2'(rand_bits(2));
        off  = 2'(rand_bits(2));
        if (size == 2'b11) begin
            size = size_word;
        end
        // aligned offsets only
        if (size == size_half) begin
            off[0] = 1'b0;
        end else if (size == size_word) begin
            off = 2'b00;
        end
        cpu_req.req  = 1'b1;
        cpu_req.wr   = 1'(rand_bits(1));
        cpu_req.size = size;
        // four tags over four sets, eight ways in total
        cpu_req.addr  = {12'h5a3, 6'h00, tsel, isel, 8'h5c, off};
        cpu_req.wdata = rand_bits(32);
        do begin
            @(posedge clk);
        end while (!cpu_rsp.data_ok);
        #1;
        cpu_req = '0;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run still busy after %0d clock cycles", cycle_limit);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        cpu_req = '0;
        rst     = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        // idle cycles, no acks expected
        repeat (3) @(posedge clk);
        #1;
        for (int n = 0; n < num_req; n++) begin
            issue_random();
            if (rand_bits(2) == 0) begin
                @(posedge clk);
                #1;
            end
        end
        repeat (4) @(posedge clk);
        $display("%0d of %0d requests checked, %0d write-backs, %0d refills, %0d errors",
                 done_count, num_req, wb_count, rd_count, err_count);
        if (err_count == 0 && done_count == num_req) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* sim/dcache_checker.sv */
`timescale 1ns/100ps

// watches both DUT ports at each rising edge
// reference is a byte memory plus a per-set model of the cache policy
module dcache_checker (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::cpu_req_t cpu_req,
    input  bus_pkg::cpu_rsp_t cpu_rsp,
    input  bus_pkg::mem_req_t mem_req,
    input  bus_pkg::mem_rsp_t mem_rsp,
    output int                err_count,
    output int                done_count
);
    import bus_pkg::*;
    import cache_pkg::*;

    // architectural memory, only bytes stored so far
    logic [7:0] bytes [logic [31:0]];

    // policy model, one entry per set
    logic                 m_valid [num_sets][num_ways];
    logic                 m_dirty [num_sets][num_ways];
    logic [tag_width-1:0] m_tag   [num_sets][num_ways];
    logic                 m_mru   [num_sets];

    // request in flight
    logic                   busy;
    logic                   first;
    logic                   pred_hit;
    logic                   pred_wb;
    logic                   way;
    logic [tag_width-1:0]   tag;
    logic [index_width-1:0] idx;
    logic [31:0]            victim_addr;
    logic [3:0]             lanes;
    int                     wb_seen;
    int                     rd_seen;
    int                     aok_seen;
    int                     req_errs;

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        logic [31:0] w;
        w = {a[31:2], 2'b00};
        return w ^ {w[15:0], w[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    // current value of the word holding address a
    function automatic logic [31:0] model_word(input logic [31:0] a);
        logic [31:0] w;
        logic [31:0] key;
        w = fill_word(a);
        for (int b = 0; b < 4; b++) begin
            key = {a[31:2], 2'(b)};
            if (bytes.exists(key)) begin
                w[8*b +: 8] = bytes[key];
            end
        end
        return w;
    endfunction

    // byte lanes of an access
    function automatic logic [3:0] lane_mask(input logic [1:0] size, input logic [1:0] off);
        if (size == size_byte) begin
            return 4'b0001 << off;
        end
        if (size == size_half) begin
            return off[1] ? 4'b1100 : 4'b0011;
        end
        return 4'b1111;
    endfunction

    function automatic logic [31:0] lane_bits(input logic [3:0] l);
        logic [31:0] m;
        for (int b = 0; b < 4; b++) begin
            m[8*b +: 8] = {8{l[b]}};
        end
        return m;
    endfunction

    task automatic value_error(input string msg);
        $display("FAILED %0t: %s", $time, msg);
        err_count++;
        req_errs++;
    endtask

    task automatic protocol_error(input string msg);
        $display("protocol error at %0t: %s", $time, msg);
        err_count++;
        req_errs++;
    endtask

    // predict hit, way and write-back from the model
    task automatic start_request();
        tag      = cpu_req.addr[31 -: tag_width];
        idx      = cpu_req.addr[offset_width +: index_width];
        pred_hit = 1'b0;
        way      = ~m_mru[idx];
        for (int w = 0; w < num_ways; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
                pred_hit = 1'b1;
                way      = w[0];
            end
        end
        pred_wb     = !pred_hit && m_valid[idx][way] && m_dirty[idx][way];
        victim_addr = {m_tag[idx][way], idx, {offset_width{1'b0}}};
        lanes       = lane_mask(cpu_req.size, cpu_req.addr[1:0]);
        wb_seen     = 0;
        rd_seen     = 0;
        aok_seen    = 0;
        req_errs    = 0;
        first       = 1'b1;
        busy        = 1'b1;
    endtask

    // accepted memory transfers of the current request
    task automatic watch_memory();
        if (mem_req.req && mem_rsp.addr_ok) begin
            // lines are one word, so every transfer is a whole word
            if (mem_req.size != size_word) begin
                value_error($sformatf("memory transfer size %0d, expected word",
                                      mem_req.size));
            end
            if (mem_req.wr) begin
                wb_seen++;
                if (rd_seen != 0) begin
                    protocol_error("write-back issued after the refill read");
                end
                if (mem_req.addr != victim_addr) begin
                    value_error($sformatf("write-back addr %h, expected %h",
                                          mem_req.addr, victim_addr));
                end
                if (mem_req.wdata != model_word(victim_addr)) begin
                    value_error($sformatf("write-back data %h, expected %h",
                                          mem_req.wdata, model_word(victim_addr)));
                end
            end else begin
                rd_seen++;
                if (mem_req.addr != {cpu_req.addr[31:2], 2'b00}) begin
                    value_error($sformatf("refill addr %h for request %h",
                                          mem_req.addr, cpu_req.addr));
                end
            end
        end
    endtask

    task automatic finish_request();
        logic [31:0] exp_word;
        logic [31:0] bit_mask;
        exp_word = model_word(cpu_req.addr);
        bit_mask = lane_bits(lanes);
        if (pred_hit) begin
            if (!first) begin
                protocol_error("hit not acknowledged in its request cycle");
            end
            if (wb_seen + rd_seen != 0 || mem_req.req) begin
                protocol_error("memory accessed on a hit");
            end
        end else begin
            if (wb_seen != (pred_wb ? 1 : 0)) begin
                protocol_error($sformatf("%0d write-backs on a miss, expected %0d",
                                         wb_seen, pred_wb ? 1 : 0));
            end
            if (rd_seen != 1) begin
                protocol_error($sformatf("%0d refill reads on a miss, expected 1", rd_seen));
            end
            if (!mem_rsp.data_ok) begin
                protocol_error("core data_ok outside the refill data_ok cycle");
            end
        end
        if (aok_seen != 1) begin
            protocol_error($sformatf("%0d core addr_ok pulses, expected 1", aok_seen));
        end
        if (!cpu_req.wr && ((cpu_rsp.rdata ^ exp_word) & bit_mask) != 0) begin
            value_error($sformatf("load %h returned %h, expected %h under mask %h",
                                  cpu_req.addr, cpu_rsp.rdata, exp_word, bit_mask));
        end
        // store lands in the byte memory
        if (cpu_req.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (lanes[b]) begin
                    bytes[{cpu_req.addr[31:2], 2'(b)}] = cpu_req.wdata[8*b +: 8];
                end
            end
        end
        // policy update, allocate on miss
        if (!pred_hit) begin
            m_valid[idx][way] = 1'b1;
            m_tag[idx][way]   = tag;
            m_dirty[idx][way] = cpu_req.wr;
        end else if (cpu_req.wr) begin
            m_dirty[idx][way] = 1'b1;
        end
        m_mru[idx] = way;
        done_count++;
        $display("req %0d %s %s addr %h size %0d%s: %s", done_count,
                 cpu_req.wr ? "store" : "load", pred_hit ? "hit" : "miss", cpu_req.addr,
                 cpu_req.size, pred_wb ? " with write-back" : "",
                 req_errs == 0 ? "ok" : "mismatch");
        busy = 1'b0;
    endtask

    initial begin
        err_count  = 0;
        done_count = 0;
        busy       = 1'b0;
        first      = 1'b0;
        for (int s = 0; s < num_sets; s++) begin
            m_mru[s] = 1'b0;
            for (int w = 0; w < num_ways; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            busy = 1'b0;
        end else begin
            if (!busy && cpu_req.req) begin
                start_request();
            end
            if (!busy) begin
                // nothing may move without a core request
                if (cpu_rsp.addr_ok || cpu_rsp.data_ok) begin
                    protocol_error("core acknowledge without a request");
                end
                if (mem_req.req) begin
                    protocol_error("memory request while the core is idle");
                end
            end else begin
                watch_memory();
                if (cpu_rsp.addr_ok) begin
                    aok_seen++;
                end
                if (cpu_rsp.data_ok) begin
                    finish_request();
                end
                first = 1'b0;
            end
        end
    end

endmodule

/* sim/mem_model.sv */
`timescale 1ns/100ps

// memory behind the cache, one transfer at a time
// addr_ok and data_ok each come after 0 to 3 idle cycles
module mem_model (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::mem_req_t mem_req,
    output bus_pkg::mem_rsp_t mem_rsp,
    output int                wb_count,
    output int                rd_count
);
    // sparse word store, unwritten words come from the fill pattern
    logic [31:0] words [logic [29:0]];
    logic [31:0] lfsr = 32'h3534a656;
    logic        wr;
    logic [31:0] addr;
    logic [31:0] wdata;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        // x^32 + x^22 + x^2 + x + 1
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // initial contents, a function of the whole word address
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        logic [31:0] w;
        w = {a[31:2], 2'b00};
        return w ^ {w[15:0], w[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    initial begin
        mem_rsp  = '0;
        wb_count = 0;
        rd_count = 0;
        forever begin
            // request seen at a clock edge
            do begin
                @(posedge clk);
            end while (rst || !mem_req.req);
            wr    = mem_req.wr;
            addr  = mem_req.addr;
            wdata = mem_req.wdata;
            #1;
            // address phase stall
            repeat (rand_bits(2)) begin
                @(posedge clk);
                #1;
            end
            mem_rsp.addr_ok = 1'b1;
            @(posedge clk);
            #1;
            mem_rsp.addr_ok = 1'b0;
            // data phase stall
            repeat (rand_bits(2)) begin
                @(posedge clk);
                #1;
            end
            if (wr) begin
                words[addr[31:2]] = wdata;
                wb_count++;
            end else begin
                mem_rsp.rdata = words.exists(addr[31:2]) ? words[addr[31:2]] : fill_word(addr);
                rd_count++;
            end
            mem_rsp.data_ok = 1'b1;
            @(posedge clk);
            #1;
            mem_rsp.data_ok = 1'b0;
            mem_rsp.rdata   = '0;
        end
    end

endmodule

/* src/dcache_top.sv */
`timescale 1ns/100ps

// data cache top, controller plus metadata and data storage
module dcache_top (
    input  logic              clk,
    input  logic              rst,

    // core data port
    input  bus_pkg::cpu_req_t cpu_req,
    output bus_pkg::cpu_rsp_t cpu_rsp,

    // memory port
    output bus_pkg::mem_req_t mem_req,
    input  bus_pkg::mem_rsp_t mem_rsp
);
    import cache_pkg::*;

    // metadata RAM wires
    logic [index_width-1:0] meta_rd_index;
    set_meta_t              meta_rd;
    logic                   meta_we;
    logic [index_width-1:0] meta_wr_index;
    set_meta_t              meta_wr;

    // data RAM wires
    logic [index_width-1:0] data_rd_index;
    set_data_t              data_rd;
    logic                   data_we;
    logic [index_width-1:0] data_wr_index;
    set_data_t              data_wr;

    dcache_ctrl ctrl_i (
        .clk           (clk),
        .rst           (rst),
        .cpu_req       (cpu_req),
        .cpu_rsp       (cpu_rsp),
        .mem_req       (mem_req),
        .mem_rsp       (mem_rsp),
        .meta_rd_index (meta_rd_index),
        .meta_rd       (meta_rd),
        .meta_we       (meta_we),
        .meta_wr_index (meta_wr_index),
        .meta_wr       (meta_wr),
        .data_rd_index (data_rd_index),
        .data_rd       (data_rd),
        .data_we       (data_we),
        .data_wr_index (data_wr_index),
        .data_wr       (data_wr)
    );

    // valid, dirty, tag per way and the mru flag
    set_ram #(.entry_t(set_meta_t)) meta_ram_i (
        .clk      (clk),
        .rst      (rst),
        .rd_index (meta_rd_index),
        .rd_entry (meta_rd),
        .wr_en    (meta_we),
        .wr_index (meta_wr_index),
        .wr_entry (meta_wr)
    );

    // one word per way
    set_ram #(.entry_t(set_data_t)) data_ram_i (
        .clk      (clk),
        .rst      (rst),
        .rd_index (data_rd_index),
        .rd_entry (data_rd),
        .wr_en    (data_we),
        .wr_index (data_wr_index),
        .wr_entry (data_wr)
    );

endmodule

/* src/dcache_ctrl.sv */
`timescale 1ns/100ps

// two-way write-back write-allocate cache controller
// all sequencing lives here, the set RAMs only store
module dcache_ctrl (
    input  logic                              clk,
    input  logic                              rst,

    // core data port
    input  bus_pkg::cpu_req_t                 cpu_req,
    output bus_pkg::cpu_rsp_t                 cpu_rsp,

    // memory port
    output bus_pkg::mem_req_t                 mem_req,
    input  bus_pkg::mem_rsp_t                 mem_rsp,

    // metadata RAM
    output logic [cache_pkg::index_width-1:0] meta_rd_index,
    input  cache_pkg::set_meta_t              meta_rd,
    output logic                              meta_we,
    output logic [cache_pkg::index_width-1:0] meta_wr_index,
    output cache_pkg::set_meta_t              meta_wr,

    // data RAM
    output logic [cache_pkg::index_width-1:0] data_rd_index,
    input  cache_pkg::set_data_t              data_rd,
    output logic                              data_we,
    output logic [cache_pkg::index_width-1:0] data_wr_index,
    output cache_pkg::set_data_t              data_wr
);
    import bus_pkg::*;
    import cache_pkg::*;

    typedef enum logic [1:0] {
        st_idle   = 2'b00,
        st_wb     = 2'b01,
        st_refill = 2'b10
    } state_t;

    state_t state;

    // memory accepted the address of the current transfer
    logic wb_addr_rcv;
    logic rf_addr_rcv;

    logic [tag_width-1:0]    tag;
    logic [index_width-1:0]  index;
    logic [offset_width-1:0] offset;

    logic [num_ways-1:0] way_hit;
    logic                hit;
    logic                way;
    logic                victim_dirty;

    logic is_idle;
    logic is_wb;
    logic is_refill;
    logic hit_ack;
    logic wb_done;
    logic refill_done;

    logic [3:0]  byte_mask;
    logic [31:0] bit_mask;
    logic [31:0] base_word;
    logic [31:0] merged_word;

    // core holds addr until data_ok, so no copy of tag/index is kept
    assign tag    = cpu_req.addr[31 -: tag_width];
    assign index  = cpu_req.addr[offset_width +: index_width];
    assign offset = cpu_req.addr[offset_width-1:0];

    assign is_idle   = (state == st_idle);
    assign is_wb     = (state == st_wb);
    assign is_refill = (state == st_refill);

    // tag compare on both ways
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            way_hit[w] = meta_rd.way[w].valid && (meta_rd.way[w].tag == tag);
        end
    end

    assign hit = |way_hit;

    // hitting way, else the way not used last
    // set metadata is untouched during a miss, so the victim stays put
    assign way          = hit ? way_hit[1] : ~meta_rd.mru;
    assign victim_dirty = meta_rd.way[way].valid && meta_rd.way[way].dirty;

    assign hit_ack     = is_idle && cpu_req.req && hit;
    assign wb_done     = is_wb && mem_rsp.data_ok;
    assign refill_done = is_refill && mem_rsp.data_ok;

    // byte lanes touched by the access
    always_comb begin
        case (cpu_req.size)
            size_byte: byte_mask = 4'b0001 << offset;
            size_half: byte_mask = 4'b0011 << {offset[1], 1'b0};
            default:   byte_mask = 4'b1111;
        endcase
        for (int b = 0; b < 4; b++) begin
            bit_mask[8*b +: 8] = {8{byte_mask[b]}};
        end
    end

    // store merges into the cached word on a hit
    // and into the fetched word in the refill cycle
    assign base_word   = is_refill ? mem_rsp.rdata : data_rd.word[way];
    assign merged_word = (base_word & ~bit_mask) | (cpu_req.wdata & bit_mask);

    // miss FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (cpu_req.req && !hit) begin
                        state <= victim_dirty ? st_wb : st_refill;
                    end
                end
                st_wb: begin
                    if (mem_rsp.data_ok) begin
                        state <= st_refill;
                    end
                end
                st_refill: begin
                    if (mem_rsp.data_ok) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // address flags, set on addr_ok and cleared with data_ok
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_addr_rcv <= 1'b0;
            rf_addr_rcv <= 1'b0;
        end else begin
            if (wb_done) begin
                wb_addr_rcv <= 1'b0;
            end else if (is_wb && mem_req.req && mem_rsp.addr_ok) begin
                wb_addr_rcv <= 1'b1;
            end
            if (refill_done) begin
                rf_addr_rcv <= 1'b0;
            end else if (is_refill && mem_req.req && mem_rsp.addr_ok) begin
                rf_addr_rcv <= 1'b1;
            end
        end
    end

    // memory request, dropped once the address is taken
    always_comb begin
        mem_req.req  = (is_wb && !wb_addr_rcv) || (is_refill && !rf_addr_rcv);
        mem_req.wr   = is_wb;
        // whole word moves in both directions
        mem_req.size = size_word;
        // write-back goes to the victim line, refill to the request word
        if (is_wb) begin
            mem_req.addr = {meta_rd.way[way].tag, index, {offset_width{1'b0}}};
        end else begin
            mem_req.addr = {tag, index, {offset_width{1'b0}}};
        end
        mem_req.wdata = data_rd.word[way];
    end

    // core response
    // hit acks in the request cycle, miss acks with the refill data
    always_comb begin
        cpu_rsp.addr_ok = hit_ack || (is_refill && mem_req.req && mem_rsp.addr_ok);
        cpu_rsp.data_ok = hit_ack || refill_done;
        cpu_rsp.rdata   = hit ? data_rd.word[way] : mem_rsp.rdata;
    end

    // RAM updates, one set at the request index
    always_comb begin
        meta_rd_index = index;
        data_rd_index = index;
        meta_wr_index = index;
        data_wr_index = index;

        meta_we = hit_ack || refill_done;
        data_we = (hit_ack && cpu_req.wr) || refill_done;

        meta_wr     = meta_rd;
        meta_wr.mru = way;
        if (refill_done) begin
            // new line, dirty straight away for a store miss
            meta_wr.way[way].valid = 1'b1;
            meta_wr.way[way].dirty = cpu_req.wr;
            meta_wr.way[way].tag   = tag;
        end else if (cpu_req.wr) begin
            meta_wr.way[way].dirty = 1'b1;
        end

        data_wr           = data_rd;
        data_wr.word[way] = cpu_req.wr ? merged_word : mem_rsp.rdata;
    end

    // write-back only for a valid dirty victim
    // relies on the core holding its address through the miss
    a_wb_dirty_victim: assert property (
        @(posedge clk) disable iff (rst)
        mem_req.wr |-> meta_rd.way[way].valid && meta_rd.way[way].dirty
    );

    // core ack always answers a live core request
    a_data_ok_has_req: assert property (
        @(posedge clk) disable iff (rst)
        cpu_rsp.data_ok |-> cpu_req.req
    );

    // memory request held with a stable address until accepted
    a_mem_req_held: assert property (
        @(posedge clk) disable iff (rst)
        mem_req.req && !mem_rsp.addr_ok |=> mem_req.req && $stable(mem_req.addr)
    );

endmodule

/* src/set_ram.sv */
`timescale 1ns/100ps

// storage for one entry per set
// read is combinational, write lands on the next rising edge
module set_ram #(
    parameter type entry_t = logic [31:0]
) (
    input  logic                              clk,
    input  logic                              rst,

    // read port, index comes straight from the core address
    input  logic [cache_pkg::index_width-1:0] rd_index,
    output entry_t                            rd_entry,

    // write port
    input  logic                              wr_en,
    input  logic [cache_pkg::index_width-1:0] wr_index,
    input  entry_t                            wr_entry
);
    import cache_pkg::*;

    // one entry per set
    entry_t entries [num_sets];

    // asynchronous read
    assign rd_entry = entries[rd_index];

    always_ff @(posedge clk) begin
        if (rst) begin
            // all-zero entry means every way invalid and clean
            for (int i = 0; i < num_sets; i++) begin
                entries[i] <= '0;
            end
        end else if (wr_en) begin
            entries[wr_index] <= wr_entry;
        end
    end

    // controller must never write through an undefined index
    // such a write would corrupt an unknown set
    a_wr_index_known: assert property (
        @(posedge clk) disable iff (rst)
        wr_en |-> !$isunknown(wr_index)
    );

endmodule

/* src/bus_pkg.sv */
package bus_pkg;

    // size codes, combined with addr[1:0] to pick byte lanes
    localparam logic [1:0] size_byte = 2'b00;
    localparam logic [1:0] size_half = 2'b01;
    localparam logic [1:0] size_word = 2'b10;

    // core side request, held stable until data_ok
    typedef struct packed {
        logic        req;
        logic        wr;
        logic [1:0]  size;
        logic [31:0] addr;
        // store data already placed in its byte lanes
        logic [31:0] wdata;
    } cpu_req_t;

    // core side response, both acks are one-cycle pulses
    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;
        logic [31:0] rdata;
    } cpu_rsp_t;

    // memory side uses the same handshake
    typedef cpu_req_t mem_req_t;
    typedef cpu_rsp_t mem_rsp_t;

endpackage

/* src/cache_pkg.sv */
package cache_pkg;

    // byte address split as tag | index | offset
    localparam int index_width  = 10;
    localparam int offset_width = 2;
    localparam int tag_width    = 32 - index_width - offset_width;

    // one set per index value
    localparam int num_sets = 2 ** index_width;

    // two-way set associative
    localparam int num_ways = 2;

    // state of one way, 22 bits with the default geometry
    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [tag_width-1:0] tag;
    } way_meta_t;

    // metadata of a whole set
    // mru names the way touched last, the other one is the victim
    typedef struct packed {
        way_meta_t [num_ways-1:0] way;
        logic                     mru;
    } set_meta_t;

    // one 32-bit word per way, lines are a single word
    typedef struct packed {
        logic [num_ways-1:0][31:0] word;
    } set_data_t;

endpackage
